//--- verilog/game_pkg.sv
`default_nettype none

package game_pkg;

    // reachable cells, border is one cell outside these
    localparam int x_min = 1;
    localparam int x_max = 18;
    localparam int y_min = 1;
    localparam int y_max = 13;

    // frame phases, counted from the vs fall
    localparam int sample_count = 0;
    localparam int move_count   = 1;
    localparam int write_count  = 16;

    typedef struct packed {
        logic [4:0] x;
        logic [3:0] y;
    } cell_pos_t;

    typedef enum logic [2:0] {
        dir_none,
        dir_up,
        dir_down,
        dir_left,
        dir_right
    } move_dir_t;

    typedef enum logic [2:0] {
        tile_player1 = 3'd0,
        tile_chaser1 = 3'd1,
        tile_player2 = 3'd2,
        tile_chaser2 = 3'd3
    } tile_t;

    // object ram word: on | tile | x | y
    typedef struct packed {
        logic      on;
        tile_t     tile;
        cell_pos_t pos;
    } obj_word_t;

    typedef enum logic [1:0] {
        playing,
        player1_wins,
        player2_wins
    } outcome_t;

    typedef enum logic [2:0] {
        idle,
        write_player1,
        write_chaser1,
        write_player2,
        write_chaser2
    } writer_state_t;

endpackage

`default_nettype wire

//--- verilog/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer
    import game_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic       vs,
    output logic      [7:0] frame_count
);

    logic vs_q;        // vs from the previous cycle
    logic frame_start; // falling edge of vs

    assign frame_start = vs_q && !vs;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs;
        end
    end

    // parked at 255 until the first frame arrives
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            frame_count <= 8'hff;
        end else if (frame_start) begin
            frame_count <= 8'(sample_count); // restart at the sample phase
        end else if (frame_count != 8'hff) begin
            frame_count <= frame_count + 8'd1; // saturating
        end
    end

endmodule

`default_nettype wire

//--- verilog/key_reader.sv
`timescale 1ns/1ps
`default_nettype none

module key_reader
    import game_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_n,
    input  wire logic [7:0] frame_count,
    input  wire logic [7:0] keys,
    output move_dir_t      dir1,
    output move_dir_t      dir2
);

    logic [7:0] pressed_q; // keys held at the last sample
    logic [7:0] pressed;
    logic [7:0] fresh;

    // nibble order is up, down, left, right from the top bit
    function automatic move_dir_t decode_dir(input logic [3:0] nib);
        case (nib)
            4'b1000: decode_dir = dir_up;
            4'b0100: decode_dir = dir_down;
            4'b0010: decode_dir = dir_left;
            4'b0001: decode_dir = dir_right;
            default: decode_dir = dir_none; // none or several keys
        endcase
    endfunction

    assign pressed = ~keys;               // keys are active low
    assign fresh   = pressed & ~pressed_q; // new presses only

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pressed_q <= 8'h00;
            dir1      <= dir_none;
            dir2      <= dir_none;
        end else if (frame_count == 8'(sample_count)) begin
            pressed_q <= pressed;
            dir1      <= decode_dir(fresh[3:0]);
            dir2      <= decode_dir(fresh[7:4]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/player_mover.sv
`timescale 1ns/1ps
`default_nettype none

module player_mover
    import game_pkg::*;
#(
    parameter int start_x = 1,
    parameter int start_y = 1
) (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic [7:0] frame_count,
    input  move_dir_t       dir,
    input  cell_pos_t       other_pos,
    output cell_pos_t       pos
);

    cell_pos_t nxt;      // candidate cell for this frame
    logic      in_field;
    logic      can_move;

    always_comb begin
        nxt = pos;
        case (dir)
            dir_up:    nxt.y = pos.y - 4'd1;
            dir_down:  nxt.y = pos.y + 4'd1;
            dir_left:  nxt.x = pos.x - 5'd1;
            dir_right: nxt.x = pos.x + 5'd1;
            default:   nxt = pos;
        endcase
    end

    // only the border blocks, no inner maze
    assign in_field = (nxt.x >= x_min) && (nxt.x <= x_max) &&
                      (nxt.y >= y_min) && (nxt.y <= y_max);

    // other player is checked at its pre-step cell
    assign can_move = (dir != dir_none) && in_field && (nxt != other_pos);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pos.x <= 5'(start_x);
            pos.y <= 4'(start_y);
        end else if (frame_count == 8'(move_count) && can_move) begin
            pos <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/chaser.sv
`timescale 1ns/1ps
`default_nettype none

module chaser
    import game_pkg::*;
#(
    parameter int start_x           = 11,
    parameter int start_y           = 11,
    parameter int chase_period_log2 = 5
) (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic [7:0] frame_count,
    input  cell_pos_t       target,
    output cell_pos_t       pos
);

    logic [chase_period_log2-1:0] period_cnt; // frames since last step
    logic [4:0]                   dx;
    logic [3:0]                   dy;
    cell_pos_t                    nxt;

    always_comb begin
        dx  = (pos.x < target.x) ? target.x - pos.x : pos.x - target.x;
        dy  = (pos.y < target.y) ? target.y - pos.y : pos.y - target.y;
        nxt = pos;
        if (dx > dy) begin
            nxt.x = (pos.x < target.x) ? pos.x + 5'd1 : pos.x - 5'd1;
        end else if (dy != 4'd0) begin
            nxt.y = (pos.y < target.y) ? pos.y + 4'd1 : pos.y - 4'd1;
        end
        // on the target already, nxt stays put
    end

    // target is always inside the field, so the step never needs a border check
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            pos.x      <= 5'(start_x);
            pos.y      <= 4'(start_y);
        end else if (frame_count == 8'(move_count)) begin
            period_cnt <= period_cnt + 1'b1;
            if (period_cnt == '0) begin
                pos <= nxt; // step frame
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/match_referee.sv
`timescale 1ns/1ps
`default_nettype none

module match_referee
    import game_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset_n,
    input  cell_pos_t pos1,
    input  cell_pos_t pos2,
    input  cell_pos_t cpos1,
    input  cell_pos_t cpos2,
    output outcome_t  outcome
);

    logic p1_caught;
    logic p2_caught;

    assign p1_caught = (pos1 == cpos1) || (pos1 == cpos2);
    assign p2_caught = (pos2 == cpos1) || (pos2 == cpos2);

    // result sticks until reset, player 1 caught wins the tie
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            outcome <= playing;
        end else if (outcome == playing) begin
            if (p1_caught) begin
                outcome <= player2_wins;
            end else if (p2_caught) begin
                outcome <= player1_wins;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/object_writer.sv
`timescale 1ns/1ps
`default_nettype none

module object_writer
    import game_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic [7:0] frame_count,
    input  cell_pos_t       pos1,
    input  cell_pos_t       cpos1,
    input  cell_pos_t       pos2,
    input  cell_pos_t       cpos2,
    output logic      [1:0] obj_addr,
    output obj_word_t       obj_data,
    output logic            obj_we
);

    writer_state_t state;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:          if (frame_count == 8'(write_count)) state <= write_player1;
                write_player1: state <= write_chaser1;
                write_chaser1: state <= write_player2;
                write_player2: state <= write_chaser2;
                default:       state <= idle; // burst done
            endcase
        end
    end

    // one word per write state, positions are stable this late in the frame
    always_comb begin
        obj_we   = 1'b1;
        obj_addr = 2'd0;
        obj_data = '0;
        case (state)
            write_player1: obj_data = '{on: 1'b1, tile: tile_player1, pos: pos1};
            write_chaser1: begin
                obj_addr = 2'd1;
                obj_data = '{on: 1'b1, tile: tile_chaser1, pos: cpos1};
            end
            write_player2: begin
                obj_addr = 2'd2;
                obj_data = '{on: 1'b1, tile: tile_player2, pos: pos2};
            end
            write_chaser2: begin
                obj_addr = 2'd3;
                obj_data = '{on: 1'b1, tile: tile_chaser2, pos: cpos2};
            end
            default: obj_we = 1'b0; // idle
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module game_controller
    import game_pkg::*;
#(
    parameter int chase_period_log2 = 5
) (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic       vs,
    input  wire logic [7:0] keys,
    output outcome_t        outcome,
    output logic      [1:0] obj_addr,
    output obj_word_t       obj_data,
    output logic            obj_we
);

    logic [7:0] frame_count; // cycles since the vs fall
    move_dir_t  dir1;
    move_dir_t  dir2;
    cell_pos_t  pos1;
    cell_pos_t  pos2;
    cell_pos_t  cpos1;
    cell_pos_t  cpos2;

    frame_timer frame_timer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .vs          (vs),
        .frame_count (frame_count)
    );

    key_reader key_reader_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .keys        (keys),
        .dir1        (dir1),
        .dir2        (dir2)
    );

    player_mover #(.start_x(1), .start_y(1)) player1_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .dir         (dir1),
        .other_pos   (pos2),
        .pos         (pos1)
    );

    player_mover #(.start_x(18), .start_y(13)) player2_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .dir         (dir2),
        .other_pos   (pos1),
        .pos         (pos2)
    );

    // each chaser hunts its own player
    chaser #(
        .start_x           (11),
        .start_y           (11),
        .chase_period_log2 (chase_period_log2)
    ) chaser1_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .target      (pos1),
        .pos         (cpos1)
    );

    chaser #(
        .start_x           (5),
        .start_y           (5),
        .chase_period_log2 (chase_period_log2)
    ) chaser2_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .target      (pos2),
        .pos         (cpos2)
    );

    match_referee match_referee_i (
        .clk     (clk),
        .reset_n (reset_n),
        .pos1    (pos1),
        .pos2    (pos2),
        .cpos1   (cpos1),
        .cpos2   (cpos2),
        .outcome (outcome)
    );

    object_writer object_writer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_count (frame_count),
        .pos1        (pos1),
        .cpos1       (cpos1),
        .pos2        (pos2),
        .cpos2       (cpos2),
        .obj_addr    (obj_addr),
        .obj_data    (obj_data),
        .obj_we      (obj_we)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released on a falling edge, away from the DUT sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/game_controller_props.sv
`timescale 1ns/1ps
`default_nettype none

module game_controller_props
    import game_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset_n,
    input wire logic       obj_we,
    input wire logic [1:0] obj_addr,
    input wire outcome_t   outcome
);

    logic [2:0] we_run; // write cycles in a row so far

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            we_run <= 3'd0;
        end else if (!obj_we) begin
            we_run <= 3'd0;
        end else if (we_run != 3'd7) begin
            we_run <= we_run + 3'd1;
        end
    end

    // a burst is four words, a fifth one in a row is an error
    burst_length: assert property (@(posedge clk) disable iff (!reset_n)
        !(obj_we && (we_run >= 3'd4)))
        else $error("obj_we high for more than four cycles in a row");

    addr_step: assert property (@(posedge clk) disable iff (!reset_n)
        (obj_we && $past(obj_we)) |-> (obj_addr == $past(obj_addr) + 2'd1))
        else $error("obj_addr did not advance by one within a burst");

    outcome_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(outcome) != playing) |-> (outcome == $past(outcome)))
        else $error("outcome left a winning value");

endmodule

// writer has no outcome, referee has no ram port
bind object_writer game_controller_props writer_props_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .obj_we   (obj_we),
    .obj_addr (obj_addr),
    .outcome  (game_pkg::playing)
);

bind match_referee game_controller_props referee_props_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .obj_we   (1'b0),
    .obj_addr (2'd0),
    .outcome  (outcome)
);

`default_nettype wire

//--- bench/tb_game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_controller
    import game_pkg::*;
();

    localparam int    num_rows     = 29;
    localparam int    frame_cycles = 40;
    localparam int    vs_low       = 2;
    localparam int    period_log2  = 2;
    localparam longint timeout_ns  = num_rows * frame_cycles * 8 + 2000;

    typedef struct packed {
        logic [7:0] keys; // active low with p2 in the high nibble
        cell_pos_t  p1;
        cell_pos_t  p2;
    } stim_row_t;

    logic       clk;
    logic       reset_n;
    logic       vs;
    logic [7:0] keys;
    outcome_t   outcome;
    logic [1:0] obj_addr;
    obj_word_t  obj_data;
    logic       obj_we;

    stim_row_t  rows [num_rows];
    logic [1:0] burst_addr [$]; // writes seen in the current frame
    obj_word_t  burst_data [$];

    cell_pos_t  m_p1; // model state
    cell_pos_t  m_p2;
    cell_pos_t  m_c1;
    cell_pos_t  m_c2;
    outcome_t   m_outcome;

    clock_gen #(.period_ns(8), .reset_cycles(10)) clock_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    game_controller #(.chase_period_log2(period_log2)) game_controller_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .vs       (vs),
        .keys     (keys),
        .outcome  (outcome),
        .obj_addr (obj_addr),
        .obj_data (obj_data),
        .obj_we   (obj_we)
    );

    function automatic cell_pos_t cell_at(input int x, input int y);
        cell_pos_t c;
        c.x = 5'(x);
        c.y = 4'(y);
        return c;
    endfunction

    function automatic stim_row_t make_row(input logic [7:0] k, input int x1, input int y1,
                                           input int x2, input int y2);
        stim_row_t r;
        r.keys = k;
        r.p1   = cell_at(x1, y1);
        r.p2   = cell_at(x2, y2);
        return r;
    endfunction

    // larger distance axis first and y wins a tie
    function automatic cell_pos_t chase_step(input cell_pos_t from, input cell_pos_t to);
        int        dx;
        int        dy;
        int        adx;
        int        ady;
        cell_pos_t next;
        dx   = int'(to.x) - int'(from.x);
        dy   = int'(to.y) - int'(from.y);
        adx  = (dx < 0) ? -dx : dx;
        ady  = (dy < 0) ? -dy : dy;
        next = from;
        if (adx > ady) begin
            next.x = 5'(int'(from.x) + ((dx > 0) ? 1 : -1));
        end else if (ady != 0) begin
            next.y = 4'(int'(from.y) + ((dy > 0) ? 1 : -1));
        end
        return next;
    endfunction

    task automatic load_table();
        rows[0]  = make_row(8'hff, 1, 1, 18, 13);  // start cells and a chaser step
        rows[1]  = make_row(8'hb7, 1, 1, 18, 13);  // up and down into border
        rows[2]  = make_row(8'hed, 1, 1, 18, 13);  // left and right into border
        rows[3]  = make_row(8'hff, 1, 1, 18, 13);
        rows[4]  = make_row(8'hde, 2, 1, 17, 13);
        rows[5]  = make_row(8'hde, 2, 1, 17, 13);  // held so no repeat
        rows[6]  = make_row(8'hde, 2, 1, 17, 13);
        rows[7]  = make_row(8'hff, 2, 1, 17, 13);
        rows[8]  = make_row(8'hde, 3, 1, 16, 13);  // pressed again after release
        rows[9]  = make_row(8'h33, 3, 1, 16, 13);  // two keys per nibble
        rows[10] = make_row(8'hde, 4, 1, 15, 13);
        rows[11] = make_row(8'h7b, 4, 2, 15, 12);
        rows[12] = make_row(8'hde, 5, 2, 14, 12);
        rows[13] = make_row(8'h7b, 5, 3, 14, 11);
        rows[14] = make_row(8'hde, 6, 3, 13, 11);
        rows[15] = make_row(8'h7b, 6, 4, 13, 10);
        rows[16] = make_row(8'hde, 7, 4, 12, 10);
        rows[17] = make_row(8'h7b, 7, 5, 12, 9);
        rows[18] = make_row(8'hde, 8, 5, 11, 9);
        rows[19] = make_row(8'h7b, 8, 6, 11, 8);
        rows[20] = make_row(8'hde, 9, 6, 10, 8);
        rows[21] = make_row(8'h7f, 9, 6, 10, 7);
        rows[22] = make_row(8'hfe, 10, 6, 10, 7);
        rows[23] = make_row(8'h7b, 10, 6, 10, 7); // each blocked by the other
        rows[24] = make_row(8'hfd, 9, 6, 10, 7);  // both caught in one frame
        rows[25] = make_row(8'hb7, 9, 5, 10, 8);
        rows[26] = make_row(8'hff, 9, 5, 10, 8);
        rows[27] = make_row(8'hff, 9, 5, 10, 8);
        rows[28] = make_row(8'hff, 9, 5, 10, 8);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // one 40 cycle frame with vs low for the first two
    task automatic run_frame(input logic [7:0] k);
        @(negedge clk);
        vs   = 1'b0;
        keys = k;
        burst_addr.delete();
        burst_data.delete();
        repeat (vs_low) @(negedge clk);
        vs = 1'b1;
        repeat (frame_cycles - vs_low - 1) @(negedge clk);
    endtask

    task automatic model_frame(input int idx);
        if ((idx % (1 << period_log2)) == 0) begin
            m_c1 = chase_step(m_c1, m_p1); // pre-step player cells
            m_c2 = chase_step(m_c2, m_p2);
        end
        m_p1 = rows[idx].p1;
        m_p2 = rows[idx].p2;
        if (m_outcome == playing) begin
            if ((m_p1 == m_c1) || (m_p1 == m_c2)) begin
                m_outcome = player2_wins;
            end else if ((m_p2 == m_c1) || (m_p2 == m_c2)) begin
                m_outcome = player1_wins;
            end
        end
    endtask

    task automatic check_frame(input int idx);
        cell_pos_t exp_pos [4];
        string     tag;
        int        i;
        exp_pos[0] = m_p1;
        exp_pos[1] = m_c1;
        exp_pos[2] = m_p2;
        exp_pos[3] = m_c2;
        if (burst_data.size() != 4) begin
            abort_run($sformatf("frame %0d: expected four object writes, saw %0d",
                                idx, burst_data.size()));
        end
        for (i = 0; i < 4; i++) begin
            tag = $sformatf("frame %0d word %0d", idx, i);
            check_equal(32'(burst_addr[i]), 32'(i), {tag, " address"});
            check_equal(32'(burst_data[i].on), 32'd1, {tag, " on bit"});
            check_equal(32'(burst_data[i].tile), 32'(i), {tag, " tile"});
            check_equal(32'(burst_data[i].pos), 32'(exp_pos[i]), {tag, " position"});
        end
        check_equal(32'(outcome), 32'(m_outcome), $sformatf("frame %0d outcome", idx));
    endtask

    always @(negedge clk) begin
        if (reset_n && obj_we) begin
            burst_addr.push_back(obj_addr);
            burst_data.push_back(obj_data);
        end
    end

    initial begin
        #(timeout_ns);
        abort_run("watchdog expired before the stimulus table was done");
    end

    initial begin
        int idx;
        vs         = 1'b1;
        keys       = 8'hff;
        load_table();
        m_p1      = cell_at(1, 1);
        m_p2      = cell_at(18, 13);
        m_c1      = cell_at(11, 11);
        m_c2      = cell_at(5, 5);
        m_outcome = playing;
        @(posedge reset_n);
        repeat (5) begin
            @(negedge clk);
            check_equal(32'(obj_we), 32'd0, "obj_we before the first frame");
            check_equal(32'(outcome), 32'(playing), "outcome after reset");
        end
        for (idx = 0; idx < num_rows; idx++) begin
            run_frame(rows[idx].keys);
            model_frame(idx);
            check_frame(idx);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/game_pkg.sv
verilog/frame_timer.sv
verilog/key_reader.sv
verilog/player_mover.sv
verilog/chaser.sv
verilog/match_referee.sv
verilog/object_writer.sv
verilog/game_controller.sv
bench/clock_gen.sv
bench/game_controller_props.sv
bench/tb_game_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the game controller testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_game_controller
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" --Mdir obj_dir -o "$top" -f tb.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "all tests passed" "$log"; then
    echo "no pass line found in $log"
    exit 1
fi
echo "simulation finished cleanly"
exit 0
